/* rtl/id_macros.svh */
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define XLEN     32
`define REG_AW   5
`define ALU_OP_W 12

// bit positions inside the one-hot alu_op.
`define ALU_ADD  0
`define ALU_SUB  1
`define ALU_SLT  2
`define ALU_SLTU 3
`define ALU_AND  4
`define ALU_NOR  5
`define ALU_OR   6
`define ALU_XOR  7
`define ALU_SLL  8
`define ALU_SRL  9
`define ALU_SRA  10
`define ALU_LUI  11

// major opcode in inst[31:26].
`define OP6_ARITH     6'h00
`define OP6_LU12I     6'h05
`define OP6_PCADDU12I 6'h07
`define OP6_MEM       6'h0a
`define OP6_JIRL      6'h13
`define OP6_B         6'h14
`define OP6_BL        6'h15
`define OP6_BEQ       6'h16
`define OP6_BNE       6'h17
`define OP6_BLT       6'h18
`define OP6_BGE       6'h19
`define OP6_BLTU      6'h1a
`define OP6_BGEU      6'h1b

// minor field inst[25:15] of the three-register and shift-immediate forms.
`define F11_ADD_W  11'h020
`define F11_SUB_W  11'h022
`define F11_SLT    11'h024
`define F11_SLTU   11'h025
`define F11_NOR    11'h028
`define F11_AND    11'h029
`define F11_OR     11'h02a
`define F11_XOR    11'h02b
`define F11_SLL_W  11'h02e
`define F11_SRL_W  11'h02f
`define F11_SRA_W  11'h030
`define F11_SLLI_W 11'h081
`define F11_SRLI_W 11'h089
`define F11_SRAI_W 11'h091

// minor field inst[25:22] of the 12-bit immediate forms.
`define F4_SLTI  4'h8
`define F4_SLTUI 4'h9
`define F4_ADDI  4'ha
`define F4_ANDI  4'hd
`define F4_ORI   4'he
`define F4_XORI  4'hf
`define F4_LD_W  4'h2
`define F4_ST_W  4'h6

`endif

/* rtl/id_pkg.sv */
`include "id_macros.svh"

package id_pkg;

    // the same word read as register fields or as immediate fields.
    typedef union packed {
        struct packed {
            logic [5:0]         op6;
            logic [10:0]        op11;
            logic [`REG_AW-1:0] rk;
            logic [`REG_AW-1:0] rj;
            logic [`REG_AW-1:0] rd;
        } fmt_3r;
        struct packed {
            logic [5:0]         op6;
            logic [3:0]         op4;
            logic [11:0]        i12;
            logic [`REG_AW-1:0] rj;
            logic [`REG_AW-1:0] rd;
        } fmt_2ri12;
        struct packed {
            logic [5:0]         op6;
            logic [15:0]        i16;
            logic [`REG_AW-1:0] rj;
            logic [`REG_AW-1:0] rd;
        } fmt_2ri16;
        struct packed {
            logic [5:0]         op6;
            logic               op1;
            logic [19:0]        i20;
            logic [`REG_AW-1:0] rd;
        } fmt_1ri20;
    } inst_u;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        inst_u            inst;
    } if_to_id_t;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
    } wb_to_rf_t;

    typedef struct packed {
        logic [`REG_AW-1:0] dest;
        logic [`XLEN-1:0]   result;
    } fwd_src_t;

    typedef struct packed {
        logic [`ALU_OP_W-1:0] alu_op;
        logic                 src1_is_pc;
        logic                 src2_is_imm;
        logic                 res_from_mem;
        logic                 gr_we;
        logic                 mem_we;
        logic                 is_load;
        logic [`REG_AW-1:0]   dest;
    } id_ctrl_t;

    typedef struct packed {
        id_ctrl_t         ctrl;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] rj_value;
        logic [`XLEN-1:0] rkd_value;
    } id_to_ex_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } br_bus_t;

    typedef enum logic [2:0] {
        bk_none,
        bk_eq,
        bk_ne,
        bk_lt,
        bk_ge,
        bk_direct,
        bk_jirl
    } br_kind_e;

endpackage

/* rtl/inst_decoder.sv */
`include "id_macros.svh"

module inst_decoder import id_pkg::*; (
    input  inst_u            inst,
    output id_ctrl_t         ctrl,
    output logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] br_offs,
    output logic [`XLEN-1:0] jirl_offs,
    output logic             use_rj,
    output logic             use_rk,
    output logic             use_rd,
    output br_kind_e         br_kind,
    output logic             is_signed_cmp
);

    logic                 is_arith;
    logic                 is_mem;
    logic [10:0]          f11;
    logic [3:0]           f4;
    logic                 add_w, sub_w, slt, sltu, nor_r, and_r, or_r, xor_r;
    logic                 sll_w, srl_w, sra_w, slli_w, srli_w, srai_w;
    logic                 addi_w, slti, sltui, andi, ori, xori;
    logic                 lu12i_w, pcaddu12i, ld_w, st_w;
    logic                 jirl, b, bl, beq, bne, blt, bge, bltu, bgeu;
    logic                 reg_op, shift_imm, alu_imm, cond_br, link;
    logic [`ALU_OP_W-1:0] alu_op;
    logic [15:0]          i16;
    logic [25:0]          i26;

    assign is_arith = inst.fmt_3r.op6 == `OP6_ARITH;
    assign is_mem   = inst.fmt_3r.op6 == `OP6_MEM;
    assign f11      = inst.fmt_3r.op11;
    assign f4       = inst.fmt_2ri12.op4;

    assign add_w  = is_arith && f11 == `F11_ADD_W;
    assign sub_w  = is_arith && f11 == `F11_SUB_W;
    assign slt    = is_arith && f11 == `F11_SLT;
    assign sltu   = is_arith && f11 == `F11_SLTU;
    assign nor_r  = is_arith && f11 == `F11_NOR;
    assign and_r  = is_arith && f11 == `F11_AND;
    assign or_r   = is_arith && f11 == `F11_OR;
    assign xor_r  = is_arith && f11 == `F11_XOR;
    assign sll_w  = is_arith && f11 == `F11_SLL_W;
    assign srl_w  = is_arith && f11 == `F11_SRL_W;
    assign sra_w  = is_arith && f11 == `F11_SRA_W;
    assign slli_w = is_arith && f11 == `F11_SLLI_W;
    assign srli_w = is_arith && f11 == `F11_SRLI_W;
    assign srai_w = is_arith && f11 == `F11_SRAI_W;

    assign slti   = is_arith && f4 == `F4_SLTI;
    assign sltui  = is_arith && f4 == `F4_SLTUI;
    assign addi_w = is_arith && f4 == `F4_ADDI;
    assign andi   = is_arith && f4 == `F4_ANDI;
    assign ori    = is_arith && f4 == `F4_ORI;
    assign xori   = is_arith && f4 == `F4_XORI;
    assign ld_w   = is_mem && f4 == `F4_LD_W;
    assign st_w   = is_mem && f4 == `F4_ST_W;

    assign lu12i_w   = inst.fmt_1ri20.op6 == `OP6_LU12I && !inst.fmt_1ri20.op1;
    assign pcaddu12i = inst.fmt_1ri20.op6 == `OP6_PCADDU12I && !inst.fmt_1ri20.op1;

    assign jirl = inst.fmt_2ri16.op6 == `OP6_JIRL;
    assign b    = inst.fmt_2ri16.op6 == `OP6_B;
    assign bl   = inst.fmt_2ri16.op6 == `OP6_BL;
    assign beq  = inst.fmt_2ri16.op6 == `OP6_BEQ;
    assign bne  = inst.fmt_2ri16.op6 == `OP6_BNE;
    assign blt  = inst.fmt_2ri16.op6 == `OP6_BLT;
    assign bge  = inst.fmt_2ri16.op6 == `OP6_BGE;
    assign bltu = inst.fmt_2ri16.op6 == `OP6_BLTU;
    assign bgeu = inst.fmt_2ri16.op6 == `OP6_BGEU;

    assign reg_op = add_w | sub_w | slt | sltu | nor_r | and_r | or_r | xor_r |
                    sll_w | srl_w | sra_w;
    assign shift_imm = slli_w | srli_w | srai_w;
    assign alu_imm   = addi_w | slti | sltui | andi | ori | xori;
    assign cond_br   = beq | bne | blt | bge | bltu | bgeu;
    assign link      = jirl | bl;

    assign alu_op[`ALU_ADD]  = add_w | addi_w | ld_w | st_w | link | pcaddu12i;
    assign alu_op[`ALU_SUB]  = sub_w;
    assign alu_op[`ALU_SLT]  = slt | slti;
    assign alu_op[`ALU_SLTU] = sltu | sltui;
    assign alu_op[`ALU_AND]  = and_r | andi;
    assign alu_op[`ALU_NOR]  = nor_r;
    assign alu_op[`ALU_OR]   = or_r | ori;
    assign alu_op[`ALU_XOR]  = xor_r | xori;
    assign alu_op[`ALU_SLL]  = sll_w | slli_w;
    assign alu_op[`ALU_SRL]  = srl_w | srli_w;
    assign alu_op[`ALU_SRA]  = sra_w | srai_w;
    assign alu_op[`ALU_LUI]  = lu12i_w;

    always_comb begin
        ctrl              = '0;
        ctrl.alu_op       = alu_op;
        ctrl.src1_is_pc   = link | pcaddu12i;
        ctrl.src2_is_imm  = shift_imm | alu_imm | ld_w | st_w | lu12i_w | pcaddu12i | link;
        ctrl.res_from_mem = ld_w;
        ctrl.is_load      = ld_w;
        ctrl.mem_we       = st_w;
        ctrl.gr_we        = reg_op | shift_imm | alu_imm | ld_w | lu12i_w | pcaddu12i | link;
        // bl writes the return address to r1; non-writers report dest 0.
        if (bl) begin
            ctrl.dest = `REG_AW'd1;
        end else if (ctrl.gr_we) begin
            ctrl.dest = inst.fmt_3r.rd;
        end
    end

    always_comb begin
        if (link) begin
            imm = `XLEN'd4;
        end else if (lu12i_w | pcaddu12i) begin
            imm = {inst.fmt_1ri20.i20, 12'b0};
        end else if (shift_imm) begin
            imm = {{(`XLEN-`REG_AW){1'b0}}, inst.fmt_3r.rk};
        end else if (andi | ori | xori) begin
            imm = {20'b0, inst.fmt_2ri12.i12};
        end else begin
            imm = {{20{inst.fmt_2ri12.i12[11]}}, inst.fmt_2ri12.i12};
        end
    end

    assign i16       = inst.fmt_2ri16.i16;
    assign i26       = {inst.fmt_2ri16.rj, inst.fmt_2ri16.rd, i16};
    assign jirl_offs = {{14{i16[15]}}, i16, 2'b0};
    assign br_offs   = (b | bl) ? {{4{i26[25]}}, i26, 2'b0} : jirl_offs;

    assign use_rd = cond_br | st_w;
    assign use_rk = reg_op;
    assign use_rj = reg_op | shift_imm | alu_imm | ld_w | st_w | jirl | cond_br;

    always_comb begin
        if (beq) br_kind = bk_eq;
        else if (bne) br_kind = bk_ne;
        else if (blt | bltu) br_kind = bk_lt;
        else if (bge | bgeu) br_kind = bk_ge;
        else if (b | bl) br_kind = bk_direct;
        else if (jirl) br_kind = bk_jirl;
        else br_kind = bk_none;
    end

    assign is_signed_cmp = blt | bge;

    // each kept instruction selects exactly one ALU operation.
    always_comb begin
        assert final ($onehot0(alu_op))
            else $error("inst_decoder: alu_op %b is not one-hot", alu_op);
    end

endmodule

/* rtl/regfile.sv */
`include "id_macros.svh"

module regfile import id_pkg::*; (
    input  logic               clk,
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    output logic [`XLEN-1:0]   rdata1,
    output logic [`XLEN-1:0]   rdata2,
    input  wb_to_rf_t          wr
);

    logic [`XLEN-1:0] regs [0:(1 << `REG_AW) - 1];

    // r0 is hardwired, so a write to it is dropped.
    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* rtl/operand_forward.sv */
`include "id_macros.svh"

module operand_forward import id_pkg::*; (
    input  logic [`REG_AW-1:0] rj,
    input  logic [`REG_AW-1:0] rk,
    input  logic [`REG_AW-1:0] rd,
    input  logic               use_rj,
    input  logic               use_rk,
    input  logic               use_rd,
    input  fwd_src_t           ex_fwd,
    input  fwd_src_t           me_fwd,
    input  fwd_src_t           wb_fwd,
    input  logic               ex_is_load,
    output logic [`REG_AW-1:0] rf_raddr1,
    output logic [`REG_AW-1:0] rf_raddr2,
    input  logic [`XLEN-1:0]   rf_rdata1,
    input  logic [`XLEN-1:0]   rf_rdata2,
    output logic [`XLEN-1:0]   rj_value,
    output logic [`XLEN-1:0]   rkd_value,
    output logic               load_stall
);

    logic [`REG_AW-1:0] src2;
    logic               use2;
    logic               rj_ex_hit;
    logic               src2_ex_hit;

    // newest producer wins: EX, then ME, then WB, then the register file.
    function automatic logic [`XLEN-1:0] pick(
        input logic [`REG_AW-1:0] idx,
        input logic               used,
        input logic [`XLEN-1:0]   rf_val
    );
        logic live;
        live = used && idx != '0;
        if (live && ex_fwd.dest == idx) return ex_fwd.result;
        if (live && me_fwd.dest == idx) return me_fwd.result;
        if (live && wb_fwd.dest == idx) return wb_fwd.result;
        return rf_val;
    endfunction

    assign src2      = use_rd ? rd : rk;
    assign use2      = use_rd | use_rk;
    assign rf_raddr1 = rj;
    assign rf_raddr2 = src2;

    always_comb begin
        rj_value  = pick(rj, use_rj, rf_rdata1);
        rkd_value = pick(src2, use2, rf_rdata2);
    end

    // a load in EX has no result yet, so a dependent instruction waits a cycle.
    assign rj_ex_hit   = use_rj && rj != '0 && rj == ex_fwd.dest;
    assign src2_ex_hit = use2 && src2 != '0 && src2 == ex_fwd.dest;
    assign load_stall  = ex_is_load && (rj_ex_hit || src2_ex_hit);

    // r0 reads zero through the whole path, whatever a later stage reports for dest 0.
    always_comb begin
        assert final (rj != '0 || rj_value == '0)
            else $error("operand_forward: r0 forwarded on rj");
        assert final (src2 != '0 || rkd_value == '0)
            else $error("operand_forward: r0 forwarded on rk/rd");
    end

endmodule

/* rtl/branch_unit.sv */
`include "id_macros.svh"

module branch_unit import id_pkg::*; (
    input  br_kind_e         br_kind,
    input  logic             is_signed_cmp,
    input  logic [`XLEN-1:0] rj_value,
    input  logic [`XLEN-1:0] rkd_value,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] br_offs,
    input  logic [`XLEN-1:0] jirl_offs,
    output logic             taken,
    output logic [`XLEN-1:0] target
);

    logic equal;
    logic greater_eq;

    assign equal = rj_value == rkd_value;

    // blt and bltu reuse the ge compare with the result inverted.
    assign greater_eq = is_signed_cmp ? ($signed(rj_value) >= $signed(rkd_value))
                                      : (rj_value >= rkd_value);

    always_comb begin
        case (br_kind)
            bk_eq:     taken = equal;
            bk_ne:     taken = !equal;
            bk_lt:     taken = !greater_eq;
            bk_ge:     taken = greater_eq;
            bk_direct: taken = 1'b1;
            bk_jirl:   taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign target = (br_kind == bk_jirl) ? rj_value + jirl_offs : pc + br_offs;

endmodule

/* rtl/id_stage.sv */
`include "id_macros.svh"

module id_stage import id_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      if_valid,
    input  if_to_id_t if_bus,
    output logic      id_allow_in,
    output logic      id_to_ex_valid,
    output id_to_ex_t id_to_ex_bus,
    input  logic      ex_allow_in,
    input  fwd_src_t  ex_fwd,
    input  fwd_src_t  me_fwd,
    input  fwd_src_t  wb_fwd,
    input  logic      ex_is_load,
    input  wb_to_rf_t wb_to_rf,
    output br_bus_t   br_bus
);

    logic               valid;
    if_to_id_t          stage_q;
    logic               ready_go;
    logic               load_stall;
    id_ctrl_t           ctrl;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   br_offs;
    logic [`XLEN-1:0]   jirl_offs;
    logic               use_rj;
    logic               use_rk;
    logic               use_rd;
    br_kind_e           br_kind;
    logic               is_signed_cmp;
    logic [`REG_AW-1:0] rf_raddr1;
    logic [`REG_AW-1:0] rf_raddr2;
    logic [`XLEN-1:0]   rf_rdata1;
    logic [`XLEN-1:0]   rf_rdata2;
    logic [`XLEN-1:0]   rj_value;
    logic [`XLEN-1:0]   rkd_value;
    logic               bu_taken;
    logic [`XLEN-1:0]   bu_target;

    assign ready_go       = valid && !load_stall;
    assign id_allow_in    = !valid || (ready_go && ex_allow_in);
    assign id_to_ex_valid = ready_go;

    // a taken branch drops whatever IF offers in the same cycle.
    // the branch itself is held while EX is not ready, so it is never lost.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (br_bus.taken && ex_allow_in) begin
            valid <= 1'b0;
        end else if (id_allow_in) begin
            valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allow_in) begin
            stage_q <= if_bus;
        end
    end

    inst_decoder u_decoder (
        .inst          (stage_q.inst),
        .ctrl          (ctrl),
        .imm           (imm),
        .br_offs       (br_offs),
        .jirl_offs     (jirl_offs),
        .use_rj        (use_rj),
        .use_rk        (use_rk),
        .use_rd        (use_rd),
        .br_kind       (br_kind),
        .is_signed_cmp (is_signed_cmp)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb_to_rf)
    );

    operand_forward u_forward (
        .rj         (stage_q.inst.fmt_3r.rj),
        .rk         (stage_q.inst.fmt_3r.rk),
        .rd         (stage_q.inst.fmt_3r.rd),
        .use_rj     (use_rj),
        .use_rk     (use_rk),
        .use_rd     (use_rd),
        .ex_fwd     (ex_fwd),
        .me_fwd     (me_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .load_stall (load_stall)
    );

    branch_unit u_branch (
        .br_kind       (br_kind),
        .is_signed_cmp (is_signed_cmp),
        .rj_value      (rj_value),
        .rkd_value     (rkd_value),
        .pc            (stage_q.pc),
        .br_offs       (br_offs),
        .jirl_offs     (jirl_offs),
        .taken         (bu_taken),
        .target        (bu_target)
    );

    assign br_bus = '{taken: bu_taken && ready_go, target: bu_target};

    assign id_to_ex_bus = '{
        ctrl:      ctrl,
        pc:        stage_q.pc,
        imm:       imm,
        rj_value:  rj_value,
        rkd_value: rkd_value
    };

    // a stalled item waits in ID and is neither issued nor replaced.
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (valid && load_stall) |=> valid && $stable(stage_q));

    // operand values may still pick up newer forwarded results while held.
    a_hold_on_backpressure: assert property (@(posedge clk) disable iff (rst)
        (id_to_ex_valid && !ex_allow_in) |=>
            valid && $stable(id_to_ex_bus.pc) && $stable(id_to_ex_bus.ctrl)
            && $stable(id_to_ex_bus.imm));

endmodule

/* verification/id_stage_tb.sv */
`include "id_macros.svh"

module id_stage_tb import id_pkg::*; ();

    localparam int N_DEC   = 150;
    localparam int N_FWD   = 80;
    localparam int N_BR    = 80;
    localparam int N_STALL = 10;
    localparam int N_BP    = 10;
    localparam int N_OUT   = N_DEC + N_FWD + N_BR + N_STALL + 2 * N_BP;
    localparam int N_ITEMS = N_OUT + 32;

    localparam logic [10:0] F11_TAB [14] = '{`F11_ADD_W, `F11_SUB_W, `F11_SLT, `F11_SLTU,
        `F11_NOR, `F11_AND, `F11_OR, `F11_XOR, `F11_SLL_W, `F11_SRL_W, `F11_SRA_W,
        `F11_SLLI_W, `F11_SRLI_W, `F11_SRAI_W};
    localparam logic [3:0] F4_TAB [6] = '{`F4_SLTI, `F4_SLTUI, `F4_ADDI, `F4_ANDI,
        `F4_ORI, `F4_XORI};
    localparam logic [5:0] BR_TAB [9] = '{`OP6_B, `OP6_BL, `OP6_JIRL, `OP6_BEQ, `OP6_BNE,
        `OP6_BLT, `OP6_BGE, `OP6_BLTU, `OP6_BGEU};

    logic        clk;
    logic        rst;
    logic        if_valid;
    if_to_id_t   if_bus;
    logic        id_allow_in;
    logic        id_to_ex_valid;
    id_to_ex_t   id_to_ex_bus;
    logic        ex_allow_in;
    fwd_src_t    ex_fwd;
    fwd_src_t    me_fwd;
    fwd_src_t    wb_fwd;
    logic        ex_is_load;
    wb_to_rf_t   wb_to_rf;
    br_bus_t     br_bus;
    logic [31:0] shadow [0:31];
    logic [31:0] lcg_state;
    id_to_ex_t   exp_q[$];
    br_bus_t     exp_br_q[$];
    int          n_checked;

    id_stage u_dut (
        .clk            (clk),
        .rst            (rst),
        .if_valid       (if_valid),
        .if_bus         (if_bus),
        .id_allow_in    (id_allow_in),
        .id_to_ex_valid (id_to_ex_valid),
        .id_to_ex_bus   (id_to_ex_bus),
        .ex_allow_in    (ex_allow_in),
        .ex_fwd         (ex_fwd),
        .me_fwd         (me_fwd),
        .wb_fwd         (wb_fwd),
        .ex_is_load     (ex_is_load),
        .wb_to_rf       (wb_to_rf),
        .br_bus         (br_bus)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    task automatic check_val(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // classes 0..23 are non-branch instructions, 24..32 are branches and jumps.
    function automatic logic [31:0] rand_inst(input int base, input int n);
        logic [31:0] r;
        logic [31:0] f;
        int          k;
        int          j;
        r = lcg();
        f = lcg();
        k = base + int'(r[23:8]) % n;
        if (k < 14) return {`OP6_ARITH, F11_TAB[k[3:0]], f[14:0]};
        j = k - 14;
        if (k < 20) return {`OP6_ARITH, F4_TAB[j[2:0]], f[21:0]};
        if (k == 20) return {`OP6_MEM, `F4_LD_W, f[21:0]};
        if (k == 21) return {`OP6_MEM, `F4_ST_W, f[21:0]};
        if (k == 22) return {`OP6_LU12I, 1'b0, f[24:0]};
        if (k == 23) return {`OP6_PCADDU12I, 1'b0, f[24:0]};
        j = k - 24;
        return {BR_TAB[j[3:0]], f[25:0]};
    endfunction

    function automatic logic [31:0] fwd_value(input logic [4:0] idx, input logic used);
        if (idx == 5'd0) return 32'd0;
        if (used && ex_fwd.dest == idx) return ex_fwd.result;
        if (used && me_fwd.dest == idx) return me_fwd.result;
        if (used && wb_fwd.dest == idx) return wb_fwd.result;
        return shadow[idx];
    endfunction

    function automatic void ref_decode(input logic [31:0] w, input logic [31:0] pc,
                                       output id_to_ex_t e, output br_bus_t br);
        logic [5:0]  op6;
        logic [10:0] f11;
        logic [3:0]  f4;
        logic [4:0]  rd, rj, rk, src2;
        logic        reg_op, shi, ai, zext, ld, st, lu, pca;
        logic        jirl, b26, bl, cond, link, urj, urk, urd, tk;
        logic [31:0] a, c, offs16, offs26;
        int          op;
        op6 = w[31:26];
        f11 = w[25:15];
        f4 = w[25:22];
        rd = w[4:0];
        rj = w[9:5];
        rk = w[14:10];
        op = -1;
        shi = 1'b0;
        if (op6 == `OP6_ARITH) begin
            case (f11)
                `F11_ADD_W:  op = `ALU_ADD;
                `F11_SUB_W:  op = `ALU_SUB;
                `F11_SLT:    op = `ALU_SLT;
                `F11_SLTU:   op = `ALU_SLTU;
                `F11_NOR:    op = `ALU_NOR;
                `F11_AND:    op = `ALU_AND;
                `F11_OR:     op = `ALU_OR;
                `F11_XOR:    op = `ALU_XOR;
                `F11_SLL_W:  op = `ALU_SLL;
                `F11_SRL_W:  op = `ALU_SRL;
                `F11_SRA_W:  op = `ALU_SRA;
                `F11_SLLI_W: begin op = `ALU_SLL; shi = 1'b1; end
                `F11_SRLI_W: begin op = `ALU_SRL; shi = 1'b1; end
                `F11_SRAI_W: begin op = `ALU_SRA; shi = 1'b1; end
                default: ;
            endcase
        end
        reg_op = op >= 0 && !shi;
        if (op6 == `OP6_ARITH) begin
            case (f4)
                `F4_SLTI:  op = `ALU_SLT;
                `F4_SLTUI: op = `ALU_SLTU;
                `F4_ADDI:  op = `ALU_ADD;
                `F4_ANDI:  op = `ALU_AND;
                `F4_ORI:   op = `ALU_OR;
                `F4_XORI:  op = `ALU_XOR;
                default: ;
            endcase
        end
        ai = op >= 0 && !reg_op && !shi;
        zext = ai && (f4 == `F4_ANDI || f4 == `F4_ORI || f4 == `F4_XORI);
        ld = op6 == `OP6_MEM && f4 == `F4_LD_W;
        st = op6 == `OP6_MEM && f4 == `F4_ST_W;
        lu = op6 == `OP6_LU12I && !w[25];
        pca = op6 == `OP6_PCADDU12I && !w[25];
        jirl = op6 == `OP6_JIRL;
        b26 = op6 == `OP6_B;
        bl = op6 == `OP6_BL;
        cond = op6 >= `OP6_BEQ && op6 <= `OP6_BGEU;
        link = jirl | bl;
        if (ld | st | link | pca) op = `ALU_ADD;
        if (lu) op = `ALU_LUI;

        e = '0;
        e.ctrl.alu_op = (op >= 0) ? (12'd1 << op) : 12'd0;
        e.ctrl.src1_is_pc = link | pca;
        e.ctrl.src2_is_imm = shi | ai | ld | st | lu | pca | link;
        e.ctrl.res_from_mem = ld;
        e.ctrl.is_load = ld;
        e.ctrl.mem_we = st;
        e.ctrl.gr_we = reg_op | shi | ai | ld | lu | pca | link;
        e.ctrl.dest = bl ? 5'd1 : (e.ctrl.gr_we ? rd : 5'd0);
        e.pc = pc;
        if (link) e.imm = 32'd4;
        else if (lu | pca) e.imm = {w[24:5], 12'b0};
        else if (shi) e.imm = {27'b0, rk};
        else if (zext) e.imm = {20'b0, w[21:10]};
        else e.imm = {{20{w[21]}}, w[21:10]};

        urd = cond | st;
        urk = reg_op;
        urj = reg_op | shi | ai | ld | st | jirl | cond;
        src2 = urd ? rd : rk;
        a = fwd_value(rj, urj);
        c = fwd_value(src2, urd | urk);
        e.rj_value = a;
        e.rkd_value = c;

        offs16 = {{14{w[25]}}, w[25:10], 2'b0};
        offs26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
        case (op6)
            `OP6_BEQ:  tk = a == c;
            `OP6_BNE:  tk = a != c;
            `OP6_BLT:  tk = $signed(a) < $signed(c);
            `OP6_BGE:  tk = $signed(a) >= $signed(c);
            `OP6_BLTU: tk = a < c;
            `OP6_BGEU: tk = a >= c;
            `OP6_B, `OP6_BL, `OP6_JIRL: tk = 1'b1;
            default:   tk = 1'b0;
        endcase
        br.taken = tk;
        br.target = jirl ? a + offs16 : pc + ((b26 | bl) ? offs26 : offs16);
    endfunction

    // a zero mask puts dest 0 on every stage with a nonzero result.
    task automatic set_fwd(input logic [4:0] mask);
        logic [31:0] r;
        r = lcg();
        ex_fwd.dest = r[4:0] & mask;
        me_fwd.dest = r[9:5] & mask;
        wb_fwd.dest = r[14:10] & mask;
        ex_fwd.result = lcg();
        me_fwd.result = lcg();
        wb_fwd.result = lcg();
    endtask

    task automatic send_item(input logic [31:0] w, input int stall);
        logic [31:0] r;
        logic [31:0] pc;
        id_to_ex_t   e;
        br_bus_t     br;
        r = lcg();
        pc = {r[31:2], 2'b00};
        if_valid = 1'b1;
        if_bus.pc = pc;
        if_bus.inst = w;
        do @(posedge clk); while (!id_allow_in);
        @(negedge clk);
        repeat (stall) begin
            check_val("id_to_ex_valid", 160'(id_to_ex_valid), 160'(0));
            check_val("id_allow_in", 160'(id_allow_in), 160'(0));
            @(negedge clk);
        end
        ex_is_load = 1'b0;
        ref_decode(w, pc, e, br);
        exp_q.push_back(e);
        exp_br_q.push_back(br);
        // offered in the taken cycle, this word must be flushed.
        if (br.taken) begin
            r = lcg();
            if_bus.inst = {`OP6_ARITH, `F11_ADD_W, r[14:0]};
            if_bus.pc = pc + 32'd4;
        end else begin
            if_valid = 1'b0;
        end
        while (exp_q.size() != 0) @(negedge clk);
        if_valid = 1'b0;
    endtask

    task automatic back_pressure();
        logic [31:0] r, pc_a, pc_b, word_a, word_b;
        id_to_ex_t   e;
        id_to_ex_t   held;
        br_bus_t     br;
        word_a = rand_inst(0, 24);
        word_b = rand_inst(0, 24);
        r = lcg();
        pc_a = {r[31:2], 2'b00};
        pc_b = pc_a + 32'd4;
        ex_allow_in = 1'b0;
        if_valid = 1'b1;
        if_bus.pc = pc_a;
        if_bus.inst = word_a;
        do @(posedge clk); while (!id_allow_in);
        @(negedge clk);
        ref_decode(word_a, pc_a, e, br);
        exp_q.push_back(e);
        exp_br_q.push_back(br);
        held = id_to_ex_bus;
        if_bus.pc = pc_b;
        if_bus.inst = word_b;
        repeat (3) begin
            @(negedge clk);
            check_val("id_allow_in", 160'(id_allow_in), 160'(0));
            check_val("id_to_ex_bus", 160'(id_to_ex_bus), 160'(held));
        end
        ex_allow_in = 1'b1;
        @(negedge clk);
        if_valid = 1'b0;
        ref_decode(word_b, pc_b, e, br);
        exp_q.push_back(e);
        exp_br_q.push_back(br);
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    always @(posedge clk) begin : compare
        id_to_ex_t e;
        br_bus_t   br;
        if (!rst && id_to_ex_valid && ex_allow_in) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t: an item left ID when none was expected", $time);
                $display("Checks failed");
                $fatal(1, "unexpected item");
            end else begin
                e = exp_q.pop_front();
                br = exp_br_q.pop_front();
                check_val("ctrl", 160'(id_to_ex_bus.ctrl), 160'(e.ctrl));
                check_val("pc", 160'(id_to_ex_bus.pc), 160'(e.pc));
                check_val("imm", 160'(id_to_ex_bus.imm), 160'(e.imm));
                check_val("rj_value", 160'(id_to_ex_bus.rj_value), 160'(e.rj_value));
                check_val("rkd_value", 160'(id_to_ex_bus.rkd_value), 160'(e.rkd_value));
                check_val("br_bus.taken", 160'(br_bus.taken), 160'(br.taken));
                if (br.taken) begin
                    check_val("br_bus.target", 160'(br_bus.target), 160'(br.target));
                end
                n_checked++;
            end
        end
    end

    initial begin : watchdog
        repeat (N_ITEMS * 20) @(posedge clk);
        $display("error: watchdog timeout, the run did not finish in time");
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] w;
        lcg_state = 32'd52;
        n_checked = 0;
        rst = 1'b1;
        if_valid = 1'b0;
        if_bus = '0;
        ex_allow_in = 1'b1;
        ex_fwd = '0;
        me_fwd = '0;
        wb_fwd = '0;
        ex_is_load = 1'b0;
        wb_to_rf = '0;
        shadow[0] = 32'd0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_val("id_to_ex_valid", 160'(id_to_ex_valid), 160'(0));
        check_val("br_bus.taken", 160'(br_bus.taken), 160'(0));
        check_val("id_allow_in", 160'(id_allow_in), 160'(1));

        for (int i = 1; i < 32; i++) begin
            wb_to_rf.we = 1'b1;
            wb_to_rf.waddr = i[4:0];
            wb_to_rf.wdata = lcg();
            shadow[i] = wb_to_rf.wdata;
            @(negedge clk);
        end
        wb_to_rf.we = 1'b0;

        repeat (N_DEC) begin
            set_fwd(5'd0);
            send_item(rand_inst(0, 24), 0);
        end
        // small register indices make the stages collide often.
        repeat (N_FWD) begin
            set_fwd(5'd3);
            send_item(rand_inst(0, 33) & 32'hffff_8c63, 0);
        end
        repeat (N_BR) begin
            set_fwd(5'd0);
            w = rand_inst(24, 9);
            r = lcg();
            if (r[0]) w[4:0] = w[9:5];
            send_item(w, 0);
        end
        repeat (N_STALL) begin
            r = lcg();
            w = {`OP6_ARITH, `F11_ADD_W, r[14:10], r[9:5] | 5'd1, r[4:0]};
            set_fwd(5'd0);
            ex_fwd.dest = w[9:5];
            ex_is_load = 1'b1;
            send_item(w, 1 + int'(r[17:16]));
        end
        repeat (N_BP) begin
            set_fwd(5'd0);
            back_pressure();
        end

        repeat (4) @(negedge clk);
        if (exp_q.size() != 0 || n_checked != N_OUT) begin
            $display("error: %0d items reached EX, %0d were expected", n_checked, N_OUT);
            $display("Checks failed");
            $fatal(1, "item count");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* id_stage.f */
+incdir+rtl
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_forward.sv
rtl/branch_unit.sv
rtl/id_stage.sv
verification/id_stage_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f id_stage.f --top-module id_stage_tb \
		-Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > run.log 2>&1 || true
	cat run.log
	grep -q "All checks passed" run.log

clean:
	rm -rf obj_dir run.log
